// ==== design/rs_pkg.sv ====
package rs_pkg;

  // operand and result width
  localparam int DATA_W = 32;
  // rob tag width
  localparam int ROB_W = 5;

  // opcodes understood by the two lanes
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } op_e;

  // execution lane class, also the rs_full bit index
  typedef enum logic {
    LANE_ALU = 1'b0,
    LANE_MUL = 1'b1
  } lane_e;

  // one source operand
  // rdy set means val is valid, else waiting on tag
  typedef struct packed {
    logic              rdy;
    logic [ROB_W-1:0]  tag;
    logic [DATA_W-1:0] val;
  } src_t;

  // instruction as issued, also the station entry layout
  typedef struct packed {
    logic             valid;
    op_e              op;
    logic [ROB_W-1:0] robid;
    src_t             a;
    src_t             b;
  } issue_t;

  // station to execution unit
  typedef struct packed {
    logic              valid;
    op_e               op;
    logic [ROB_W-1:0]  robid;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } disp_t;

  // one common data bus beat
  typedef struct packed {
    logic              valid;
    logic [ROB_W-1:0]  robid;
    logic [DATA_W-1:0] data;
  } cdb_t;

endpackage

// ==== design/rs_station.sv ====
`timescale 1ns/1ps

module rs_station #(
  parameter rs_pkg::lane_e LANE = rs_pkg::LANE_ALU,
  parameter int RS_ENTRIES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  rs_pkg::issue_t                    issue,
  input  rs_pkg::cdb_t                      cdb,
  input  logic                              fu_busy,
  output rs_pkg::disp_t                     disp,
  output logic                              full,
  output logic [$clog2(RS_ENTRIES + 1)-1:0] count
);

  import rs_pkg::*;

  localparam int CNT_W = $clog2(RS_ENTRIES + 1);
  localparam int IDX_W = $clog2(RS_ENTRIES);

  // entry array, same layout as an issued instruction
  issue_t [RS_ENTRIES-1:0] ents;
  issue_t [RS_ENTRIES-1:0] ent_next;

  lane_e            issue_lane;
  logic             take;
  logic             alloc_hit;
  logic [IDX_W-1:0] alloc_idx;
  logic             pick_hit;
  logic [IDX_W-1:0] pick_idx;
  logic             do_disp;

  // capture cdb data into a waiting source on tag match
  function automatic src_t wake_src(src_t s, cdb_t c);
    src_t r;
    r = s;
    if (!s.rdy && c.valid && (c.robid == s.tag)) begin
      r.rdy = 1'b1;
      r.val = c.data;
    end
    return r;
  endfunction

  // only multiplies go to the mul lane
  always_comb begin
    issue_lane = (issue.op == OP_MUL) ? LANE_MUL : LANE_ALU;
    take       = issue.valid && (issue_lane == LANE);
  end

  // lowest free entry
  // scan downward so the lowest index wins
  always_comb begin
    alloc_hit = 1'b0;
    alloc_idx = '0;
    for (int e = RS_ENTRIES - 1; e >= 0; e--) begin
      if (!ents[e].valid) begin
        alloc_hit = 1'b1;
        alloc_idx = IDX_W'(e);
      end
    end
  end

  // lowest entry with both sources ready
  // uses registered state, so a fresh entry waits one cycle
  always_comb begin
    pick_hit = 1'b0;
    pick_idx = '0;
    for (int e = RS_ENTRIES - 1; e >= 0; e--) begin
      if (ents[e].valid && ents[e].a.rdy && ents[e].b.rdy) begin
        pick_hit = 1'b1;
        pick_idx = IDX_W'(e);
      end
    end
  end

  // unit busy holds the pick in place
  assign do_disp = pick_hit && !fu_busy;

  always_comb begin
    ent_next = ents;
    // tag wakeup on every live entry
    for (int e = 0; e < RS_ENTRIES; e++) begin
      if (ents[e].valid) begin
        ent_next[e].a = wake_src(ents[e].a, cdb);
        ent_next[e].b = wake_src(ents[e].b, cdb);
      end
    end
    // dispatched entry frees at the same edge
    if (do_disp) begin
      ent_next[pick_idx].valid = 1'b0;
    end
    // new issue, with same-cycle cdb capture
    if (take && alloc_hit) begin
      ent_next[alloc_idx]       = issue;
      ent_next[alloc_idx].valid = 1'b1;
      ent_next[alloc_idx].a     = wake_src(issue.a, cdb);
      ent_next[alloc_idx].b     = wake_src(issue.b, cdb);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int e = 0; e < RS_ENTRIES; e++) begin
        ents[e].valid <= 1'b0;
      end
    end else begin
      ents <= ent_next;
    end
  end

  // disp stays put while the unit is busy
  always_ff @(posedge clk) begin
    if (rst) begin
      disp.valid <= 1'b0;
    end else if (!fu_busy) begin
      disp.valid <= pick_hit;
      disp.op    <= ents[pick_idx].op;
      disp.robid <= ents[pick_idx].robid;
      disp.a     <= ents[pick_idx].a.val;
      disp.b     <= ents[pick_idx].b.val;
    end
  end

  // occupancy
  always_comb begin
    count = '0;
    for (int e = 0; e < RS_ENTRIES; e++) begin
      count = count + CNT_W'(ents[e].valid);
    end
  end

  assign full = (count == CNT_W'(RS_ENTRIES));

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
  input  logic          clk,
  input  logic          rst,
  input  rs_pkg::disp_t disp,
  input  logic          grant,
  output rs_pkg::cdb_t  req,
  output logic          busy
);

  import rs_pkg::*;

  logic [DATA_W-1:0] alu_out;

  // single-cycle integer ops
  always_comb begin
    case (disp.op)
      OP_ADD:  alu_out = disp.a + disp.b;
      OP_SUB:  alu_out = disp.a - disp.b;
      OP_AND:  alu_out = disp.a & disp.b;
      OP_OR:   alu_out = disp.a | disp.b;
      OP_XOR:  alu_out = disp.a ^ disp.b;
      // mul never reaches this lane
      default: alu_out = '0;
    endcase
  end

  // held result not leaving this cycle
  assign busy = req.valid && !grant;

  // result register doubles as the cdb request
  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else if (!busy) begin
      req.valid <= disp.valid;
      req.robid <= disp.robid;
      req.data  <= alu_out;
    end
  end

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
  input  logic          clk,
  input  logic          rst,
  input  rs_pkg::disp_t disp,
  input  logic          grant,
  output rs_pkg::cdb_t  req,
  output logic          busy
);

  import rs_pkg::*;

  // stage one holds operands and tag
  typedef struct packed {
    logic              valid;
    logic [ROB_W-1:0]  robid;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } mul_s1_t;

  mul_s1_t           s1;
  logic              advance;
  logic [DATA_W-1:0] prod_lo;

  // low half of the product only
  assign prod_lo = s1.a * s1.b;

  // stage two free or leaving this cycle
  assign advance = !req.valid || grant;

  // stage one stuck behind a held result
  assign busy = s1.valid && !advance;

  // stage two, also the cdb request
  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else if (advance) begin
      req.valid <= s1.valid;
      req.robid <= s1.robid;
      req.data  <= prod_lo;
    end
  end

  // stage one
  // loads whenever it is empty or moving on
  always_ff @(posedge clk) begin
    if (rst) begin
      s1.valid <= 1'b0;
    end else if (!busy) begin
      s1.valid <= disp.valid;
      s1.robid <= disp.robid;
      s1.a     <= disp.a;
      s1.b     <= disp.b;
    end
  end

endmodule

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic         clk,
  input  logic         rst,
  input  rs_pkg::cdb_t alu_req,
  input  rs_pkg::cdb_t mul_req,
  output logic         alu_grant,
  output logic         mul_grant,
  output rs_pkg::cdb_t cdb
);

  import rs_pkg::*;

  cdb_t win;

  // fixed priority
  // mul first, its pipe backs up further
  always_comb begin
    mul_grant = mul_req.valid;
    alu_grant = alu_req.valid && !mul_req.valid;
  end

  // beat of the winner
  always_comb begin
    if (mul_grant) begin
      win = mul_req;
    end else if (alu_grant) begin
      win = alu_req;
    end else begin
      win = '0;
    end
  end

  // one broadcast per cycle, a cycle after grant
  always_ff @(posedge clk) begin
    if (rst) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= win.valid;
      cdb.robid <= win.robid;
      cdb.data  <= win.data;
    end
  end

endmodule

// ==== design/rs_core.sv ====
`timescale 1ns/1ps

module rs_core #(
  parameter int RS_ENTRIES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  rs_pkg::issue_t                    issue,
  output rs_pkg::cdb_t                      cdb,
  output logic [1:0]                        rs_full,
  output logic [$clog2(RS_ENTRIES + 1)-1:0] rs_count_alu,
  output logic [$clog2(RS_ENTRIES + 1)-1:0] rs_count_mul
);

  import rs_pkg::*;

  // station to unit
  disp_t disp_alu;
  disp_t disp_mul;

  // unit back-pressure
  logic  busy_alu;
  logic  busy_mul;

  // unit results toward the bus
  cdb_t  req_alu;
  cdb_t  req_mul;
  logic  grant_alu;
  logic  grant_mul;

  // alu lane station
  rs_station #(
    .LANE       (LANE_ALU),
    .RS_ENTRIES (RS_ENTRIES)
  ) rs_alu_inst (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .cdb     (cdb),
    .fu_busy (busy_alu),
    .disp    (disp_alu),
    .full    (rs_full[LANE_ALU]),
    .count   (rs_count_alu)
  );

  // mul lane station
  rs_station #(
    .LANE       (LANE_MUL),
    .RS_ENTRIES (RS_ENTRIES)
  ) rs_mul_inst (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .cdb     (cdb),
    .fu_busy (busy_mul),
    .disp    (disp_mul),
    .full    (rs_full[LANE_MUL]),
    .count   (rs_count_mul)
  );

  alu_unit alu_inst (
    .clk   (clk),
    .rst   (rst),
    .disp  (disp_alu),
    .grant (grant_alu),
    .req   (req_alu),
    .busy  (busy_alu)
  );

  mul_unit mul_inst (
    .clk   (clk),
    .rst   (rst),
    .disp  (disp_mul),
    .grant (grant_mul),
    .req   (req_mul),
    .busy  (busy_mul)
  );

  // shared bus, fed back to both stations
  cdb_arbiter arb_inst (
    .clk       (clk),
    .rst       (rst),
    .alu_req   (req_alu),
    .mul_req   (req_mul),
    .alu_grant (grant_alu),
    .mul_grant (grant_mul),
    .cdb       (cdb)
  );

endmodule

// ==== test/rs_core_assert.sv ====
`timescale 1ns/1ps

module rs_core_assert #(
  parameter int RS_ENTRIES = 4
) (
  input logic                              clk,
  input logic                              rst,
  input rs_pkg::issue_t                    issue,
  input rs_pkg::cdb_t                      cdb,
  input logic [1:0]                        rs_full,
  input logic [$clog2(RS_ENTRIES + 1)-1:0] rs_count_alu,
  input logic [$clog2(RS_ENTRIES + 1)-1:0] rs_count_mul
);

  import rs_pkg::*;

  localparam int CNT_W = $clog2(RS_ENTRIES + 1);

  logic issue_mul;

  assign issue_mul = (issue.op == OP_MUL);

  cdb_valid_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(cdb.valid))
    else $error("cdb.valid is unknown");

  // rs_full is indexed by lane
  issue_lane_not_full: assert property (@(posedge clk) disable iff (rst)
    issue.valid |-> !rs_full[issue_mul])
    else $error("issue targets a full lane");

  // one issue in and one dispatch out per edge at most
  alu_count_step: assert property (@(posedge clk) disable iff (rst)
    (rs_count_alu <= CNT_W'(RS_ENTRIES)) &&
    (32'(rs_count_alu) <= 32'($past(rs_count_alu)) + 1) &&
    (32'($past(rs_count_alu)) <= 32'(rs_count_alu) + 1))
    else $error("alu station count above RS_ENTRIES or moved by more than one");

  mul_count_step: assert property (@(posedge clk) disable iff (rst)
    (rs_count_mul <= CNT_W'(RS_ENTRIES)) &&
    (32'(rs_count_mul) <= 32'($past(rs_count_mul)) + 1) &&
    (32'($past(rs_count_mul)) <= 32'(rs_count_mul) + 1))
    else $error("mul station count above RS_ENTRIES or moved by more than one");

endmodule

bind rs_core rs_core_assert #(
  .RS_ENTRIES (RS_ENTRIES)
) rs_core_assert_inst (
  .clk          (clk),
  .rst          (rst),
  .issue        (issue),
  .cdb          (cdb),
  .rs_full      (rs_full),
  .rs_count_alu (rs_count_alu),
  .rs_count_mul (rs_count_mul)
);

// ==== test/tb_rs_core.sv ====
`timescale 1ns/1ps

module tb_rs_core;

  import rs_pkg::*;

  localparam int RS_ENTRIES = 4;
  localparam int CNT_W      = $clog2(RS_ENTRIES + 1);
  localparam int MAX_LINES  = 64;
  // op robid a_rdy a_tag a_val b_rdy b_tag b_val expected
  localparam int FIELDS     = 9;

  logic             clk;
  logic             rst;
  issue_t           issue;
  cdb_t             cdb;
  logic [1:0]       rs_full;
  logic [CNT_W-1:0] rs_count_alu;
  logic [CNT_W-1:0] rs_count_mul;

  logic [31:0] stim_mem [0:FIELDS*MAX_LINES-1];
  int          n_lines;
  bit          loaded;
  // line index per robid, -1 when unused
  int          robid_line [0:31];
  bit          seen [0:31];
  int          beats_seen;
  int          errors;
  int          tests;
  bit          full_seen;
  // mul occupancy when full first rose
  int          full_count;

  rs_core #(
    .RS_ENTRIES (RS_ENTRIES)
  ) rs_core_inst (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .cdb          (cdb),
    .rs_full      (rs_full),
    .rs_count_alu (rs_count_alu),
    .rs_count_mul (rs_count_mul)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] stim_field(int ln, int f);
    return stim_mem[ln*FIELDS+f];
  endfunction

  function automatic lane_e lane_of(op_e op);
    return (op == OP_MUL) ? LANE_MUL : LANE_ALU;
  endfunction

  // a waiting source whose producer already broadcast goes in as ready
  // one still waiting carries a wrong value, only a cdb capture repairs it
  function automatic src_t make_src(logic [31:0] rdy, logic [31:0] tag, logic [31:0] val);
    src_t s;
    s.rdy = rdy[0] || seen[tag[4:0]] || (cdb.valid && (cdb.robid == tag[4:0]));
    s.tag = tag[4:0];
    s.val = s.rdy ? val : ~val;
    return s;
  endfunction

  function automatic issue_t build_issue(int ln);
    issue_t t;
    t.valid = 1'b1;
    t.op    = op_e'(3'(stim_field(ln, 0)));
    t.robid = 5'(stim_field(ln, 1));
    t.a     = make_src(stim_field(ln, 2), stim_field(ln, 3), stim_field(ln, 4));
    t.b     = make_src(stim_field(ln, 5), stim_field(ln, 6), stim_field(ln, 7));
    return t;
  endfunction

  // the pending issue counts against the lane too
  function automatic bit lane_blocked(lane_e l);
    logic [CNT_W-1:0] cnt;
    cnt = (l == LANE_MUL) ? rs_count_mul : rs_count_alu;
    return rs_full[l] ||
           (issue.valid && (lane_of(issue.op) == l) && (cnt >= CNT_W'(RS_ENTRIES - 1)));
  endfunction

  function automatic bit producer_missing(int ln);
    return (stim_field(ln, 2) == 0 && !seen[5'(stim_field(ln, 3))]) ||
           (stim_field(ln, 5) == 0 && !seen[5'(stim_field(ln, 6))]);
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    tests++;
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      errors++;
    end else begin
      $display("ok: %s = %h", name, act);
    end
  endtask

  // cdb monitor, one lookup per beat
  always @(posedge clk) begin
    int ln;
    if (!rst) begin
      if (rs_full[LANE_MUL] && !full_seen) begin
        full_seen  = 1'b1;
        full_count = int'(rs_count_mul);
      end
      if (cdb.valid) begin
        ln = robid_line[cdb.robid];
        if (ln < 0) begin
          $display("Error: beat for robid %0d which is in no stimulus line", cdb.robid);
          errors++;
        end else if (seen[cdb.robid]) begin
          $display("Error: robid %0d was broadcast more than once", cdb.robid);
          errors++;
        end else begin
          if (producer_missing(ln)) begin
            $display("Error: robid %0d was broadcast before its producer", cdb.robid);
            errors++;
          end
          seen[cdb.robid] = 1'b1;
          beats_seen++;
          check_value($sformatf("line %0d robid %0d", ln, cdb.robid),
                      stim_field(ln, 8), cdb.data);
        end
      end
    end
  end

  initial begin
    int    gap;
    lane_e l;
    void'($urandom(36));
    errors     = 0;
    tests      = 0;
    beats_seen = 0;
    full_seen  = 1'b0;
    full_count = 0;
    loaded     = 1'b0;
    rst        = 1'b1;
    issue      = '0;
    for (int r = 0; r < 32; r++) begin
      robid_line[r] = -1;
      seen[r]       = 1'b0;
    end
    $readmemh("test/rs_stimulus.txt", stim_mem);
    // ff in the op column ends the list
    n_lines = 0;
    while (n_lines < MAX_LINES && stim_field(n_lines, 0) != 32'hff) begin
      robid_line[5'(stim_field(n_lines, 1))] = n_lines;
      n_lines++;
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset rs_full", 32'h0, 32'(rs_full));
    check_value("reset rs_count_alu", 32'h0, 32'(rs_count_alu));
    check_value("reset rs_count_mul", 32'h0, 32'(rs_count_mul));
    for (int ln = 0; ln < n_lines; ln++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clk);
        issue.valid <= 1'b0;
      end
      l = lane_of(op_e'(3'(stim_field(ln, 0))));
      @(negedge clk);
      // hold off while the target lane has no room
      while (lane_blocked(l)) begin
        @(posedge clk);
        issue.valid <= 1'b0;
        @(negedge clk);
      end
      @(posedge clk);
      issue <= build_issue(ln);
    end
    @(posedge clk);
    issue.valid <= 1'b0;
    wait (beats_seen == n_lines);
    // room for any stray beat to show up
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_value("drained rs_count_alu", 32'h0, 32'(rs_count_alu));
    check_value("drained rs_count_mul", 32'h0, 32'(rs_count_mul));
    check_value("mul lane reached full", 32'h1, 32'(full_seen));
    check_value("mul lane count at full", 32'(RS_ENTRIES), 32'(full_count));
    $display("%0d checks, %0d errors, %0d of %0d results seen",
             tests, errors, beats_seen, n_lines);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (20 * n_lines + 100) @(posedge clk);
    $display("Timeout: only %0d of %0d results reached the cdb", beats_seen, n_lines);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== test/rs_stimulus.txt ====
// op robid a_rdy a_tag a_val b_rdy b_tag b_val expected  (op 0 add 1 sub 2 and 3 or 4 xor 5 mul)
// a waiting source carries its producer's result in the val column
0 00 1 00 00000005 1 00 00000007 0000000c
1 01 1 00 00000010 1 00 00000003 0000000d
2 02 1 00 f0f0f0f0 1 00 0ff00ff0 00f000f0
3 03 1 00 12340000 1 00 00005678 12345678
4 04 1 00 ffff0000 1 00 0f0f0f0f f0f00f0f
1 05 1 00 00000001 1 00 00000002 ffffffff
// multiplies mixed with alu traffic
5 06 1 00 00000003 1 00 00000004 0000000c
0 07 1 00 00000100 1 00 00000200 00000300
5 08 1 00 00010000 1 00 00010000 00000000
5 09 1 00 ffffffff 1 00 00000002 fffffffe
4 0a 1 00 aaaaaaaa 1 00 55555555 ffffffff
5 0b 1 00 00001234 1 00 00000010 00012340
// dependent chains
0 0c 0 00 0000000c 1 00 00000001 0000000d
1 0d 0 0c 0000000d 0 01 0000000d 00000000
5 0e 0 0c 0000000d 1 00 00000003 00000027
3 0f 0 0e 00000027 1 00 00000100 00000127
4 10 0 0f 00000127 0 0e 00000027 00000100
2 11 0 10 00000100 1 00 ffffffff 00000100
// slow producer, then a burst of waiting multiplies
5 12 1 00 00000002 1 00 00000003 00000006
5 13 0 12 00000006 1 00 00000007 0000002a
5 14 0 13 0000002a 1 00 00000002 00000054
0 15 0 14 00000054 1 00 00000001 00000055
5 16 0 15 00000055 1 00 00000002 000000aa
5 17 0 15 00000055 1 00 00000003 000000ff
5 18 1 00 00000004 0 15 00000055 00000154
5 19 0 15 00000055 0 15 00000055 00001c39
5 1a 0 16 000000aa 1 00 00000001 000000aa
0 1b 0 1a 000000aa 0 19 00001c39 00001ce3
1 1c 1 00 00000000 0 1b 00001ce3 ffffe31d
0 1d 0 1c ffffe31d 0 1c ffffe31d ffffc63a
// end marker
ff 00 0 00 00000000 0 00 00000000 00000000

// ==== files.f ====
design/rs_pkg.sv
design/rs_station.sv
design/alu_unit.sv
design/mul_unit.sv
design/cdb_arbiter.sv
design/rs_core.sv
test/rs_core_assert.sv
test/tb_rs_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_rs_core
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
